//--- src/aib_avmm_pkg.sv
/*
 * Register bus definitions for the I/O redundancy block.
 * Addresses are half-word addresses on a 16-bit port with two byte enables.
 * Byte enable bit 0 always selects data bits 7:0, in both halves.
 */
`default_nettype none

package aib_avmm_pkg;

   localparam int AVMM_ADDR_W = 7;
   localparam int AVMM_DATA_W = 16;

   // Redundancy word map, low and high halves
   localparam logic [AVMM_ADDR_W-1:0] ADDR_REDUND_0_LO = 7'h20;
   localparam logic [AVMM_ADDR_W-1:0] ADDR_REDUND_0_HI = 7'h22;
   localparam logic [AVMM_ADDR_W-1:0] ADDR_REDUND_1_LO = 7'h24;
   localparam logic [AVMM_ADDR_W-1:0] ADDR_REDUND_1_HI = 7'h26;
   localparam logic [AVMM_ADDR_W-1:0] ADDR_REDUND_2_LO = 7'h28;
   localparam logic [AVMM_ADDR_W-1:0] ADDR_REDUND_2_HI = 7'h2a;
   localparam logic [AVMM_ADDR_W-1:0] ADDR_REDUND_3_LO = 7'h1c;
   localparam logic [AVMM_ADDR_W-1:0] ADDR_REDUND_3_HI = 7'h1e;

   // Raw request as seen on the port
   typedef struct packed {
      logic                   read;
      logic                   write;
      logic [AVMM_ADDR_W-1:0] address;
      logic [1:0]             byteenable;
      logic [AVMM_DATA_W-1:0] writedata;
   } avmm_req_t;

   // Decoded register write
   typedef struct packed {
      logic                   write;
      logic [1:0]             word_sel;
      logic                   hi_half;
      logic [1:0]             byte_en;
      logic [AVMM_DATA_W-1:0] data;
   } csr_wr_t;

   // Decoded register read, hit is clear for unmapped addresses
   typedef struct packed {
      logic       read;
      logic       hit;
      logic [1:0] word_sel;
      logic       hi_half;
   } csr_rd_t;

endpackage

`default_nettype wire

//--- src/aib_redund_pkg.sv
/*
 * Lane redundancy definitions: 32 data lanes on 33 pads, one pad spare.
 * Each redundancy word is read per lane by the shifter and per half by the bus.
 */
`default_nettype none

package aib_redund_pkg;

   localparam int NUM_LANES = 32;
   // One spare pad above the top lane
   localparam int NUM_PADS  = NUM_LANES + 1;

   typedef struct packed {
      logic [NUM_LANES/2-1:0] hi;
      logic [NUM_LANES/2-1:0] lo;
   } redund_half_t;

   // Same 32 bits, seen as lane bits or as two bus halves
   typedef union packed {
      logic [NUM_LANES-1:0] lanes;
      redund_half_t         half;
   } redund_word_u;

   // Field order follows the register words
   //   tx_shift  redund_0
   //   rx_shift  redund_1
   //   rx_mask   redund_2
   //   tx_mask   redund_3
   typedef struct packed {
      redund_word_u tx_shift;
      redund_word_u rx_shift;
      redund_word_u rx_mask;
      redund_word_u tx_mask;
   } redund_cfg_t;

endpackage

`default_nettype wire

//--- src/aib_avmm_decode.sv
/*
 * Combinational address decode of one bus request.
 * Unmapped writes are dropped, unmapped reads still complete as a miss.
 */
`timescale 1ns/1ps
`default_nettype none

module aib_avmm_decode
   import aib_avmm_pkg::*;
(
   input  logic      clk,
   input  logic      reset_n,
   input  avmm_req_t req,
   output csr_wr_t   wr,
   output csr_rd_t   rd
);

   logic       hit;
   logic [1:0] word_sel;
   logic       hi_half;

   always_comb begin
      hit      = 1'b1;
      word_sel = 2'd0;
      hi_half  = 1'b0;
      case (req.address)
         ADDR_REDUND_0_LO: word_sel = 2'd0;
         ADDR_REDUND_0_HI: begin
            word_sel = 2'd0;
            hi_half  = 1'b1;
         end
         ADDR_REDUND_1_LO: word_sel = 2'd1;
         ADDR_REDUND_1_HI: begin
            word_sel = 2'd1;
            hi_half  = 1'b1;
         end
         ADDR_REDUND_2_LO: word_sel = 2'd2;
         ADDR_REDUND_2_HI: begin
            word_sel = 2'd2;
            hi_half  = 1'b1;
         end
         ADDR_REDUND_3_LO: word_sel = 2'd3;
         ADDR_REDUND_3_HI: begin
            word_sel = 2'd3;
            hi_half  = 1'b1;
         end
         default:          hit = 1'b0;
      endcase
   end

   assign wr = '{write: req.write & hit, word_sel: word_sel, hi_half: hi_half,
                 byte_en: req.byteenable, data: req.writedata};

   assign rd = '{read: req.read, hit: hit, word_sel: word_sel, hi_half: hi_half};

   // The master issues one access per cycle
   a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (!reset_n)
      !(req.read && req.write));

endmodule

`default_nettype wire

//--- src/aib_io_csr.sv
/*
 * Four 32-bit redundancy words written a byte at a time over the 16-bit bus.
 * A write shows on cfg one cycle after the write strobe. Reset clears all
 * words, which gives a straight-through lane mapping.
 */
`timescale 1ns/1ps
`default_nettype none

module aib_io_csr
   import aib_avmm_pkg::*;
   import aib_redund_pkg::*;
(
   input  logic        clk,
   input  logic        reset_n,
   input  csr_wr_t     wr,
   output redund_cfg_t cfg
);

   redund_word_u [3:0]     words;
   logic [AVMM_DATA_W-1:0] half_old;
   logic [AVMM_DATA_W-1:0] half_new;

   // Merge enabled bytes into the addressed half
   always_comb begin
      if (wr.hi_half) begin
         half_old = words[wr.word_sel].half.hi;
      end else begin
         half_old = words[wr.word_sel].half.lo;
      end
      half_new[7:0]  = wr.byte_en[0] ? wr.data[7:0]  : half_old[7:0];
      half_new[15:8] = wr.byte_en[1] ? wr.data[15:8] : half_old[15:8];
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         words <= '0;
      end else if (wr.write) begin
         if (wr.hi_half) begin
            words[wr.word_sel].half.hi <= half_new;
         end else begin
            words[wr.word_sel].half.lo <= half_new;
         end
      end
   end

   // Word index follows the redund_N numbering
   assign cfg.tx_shift = words[0];
   assign cfg.rx_shift = words[1];
   assign cfg.rx_mask  = words[2];
   assign cfg.tx_mask  = words[3];

   // Decoder must never hand over a write with an undefined target word
   a_word_sel_known: assert property (@(posedge clk) disable iff (!reset_n)
      wr.write |-> !$isunknown(wr.word_sel));

endmodule

`default_nettype wire

//--- src/aib_avmm_readback.sv
/*
 * Read data return stage. Data and valid come one cycle after read.
 * readdata holds its last value between reads; a miss returns zero.
 */
`timescale 1ns/1ps
`default_nettype none

module aib_avmm_readback
   import aib_avmm_pkg::*;
   import aib_redund_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset_n,
   input  csr_rd_t                rd,
   input  redund_cfg_t            cfg,
   output logic [AVMM_DATA_W-1:0] readdata,
   output logic                   readdatavalid
);

   redund_word_u           sel_word;
   logic [AVMM_DATA_W-1:0] rdata_next;

   always_comb begin
      case (rd.word_sel)
         2'd0:    sel_word = cfg.tx_shift;
         2'd1:    sel_word = cfg.rx_shift;
         2'd2:    sel_word = cfg.rx_mask;
         default: sel_word = cfg.tx_mask;
      endcase
      if (!rd.hit) begin
         rdata_next = '0;
      end else if (rd.hi_half) begin
         rdata_next = sel_word.half.hi;
      end else begin
         rdata_next = sel_word.half.lo;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         readdata      <= '0;
         readdatavalid <= 1'b0;
      end else begin
         readdatavalid <= rd.read;
         if (rd.read) begin
            readdata <= rdata_next;
         end
      end
   end

endmodule

`default_nettype wire

//--- src/aib_redund_lane_shift.sv
/*
 * Steers 32 lanes around one failed pad on a 33-pad bus, both directions.
 * Each direction is registered, so outputs lag their inputs by one cycle.
 * A valid shift vector is a contiguous run of ones ending at bit 31.
 */
`timescale 1ns/1ps
`default_nettype none

module aib_redund_lane_shift
   import aib_redund_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset_n,
   input  redund_cfg_t          cfg,
   input  logic [NUM_LANES-1:0] tx_lanes,
   output logic [NUM_PADS-1:0]  tx_pads,
   input  logic [NUM_PADS-1:0]  rx_pads,
   output logic [NUM_LANES-1:0] rx_lanes
);

   logic [NUM_LANES-1:0] tx_eff;
   logic [NUM_PADS-1:0]  tx_next;
   logic [NUM_LANES-1:0] rx_next;

   // Transmit: masked lanes drive zero, shifted lanes move up one pad
   always_comb begin
      tx_eff     = tx_lanes & ~cfg.tx_mask.lanes;
      tx_next[0] = tx_eff[0];
      for (int i = 1; i < NUM_LANES; i++) begin
         if (cfg.tx_shift.lanes[i-1]) begin
            tx_next[i] = tx_eff[i-1];
         end else begin
            tx_next[i] = tx_eff[i];
         end
      end
      // Spare pad only carries the top lane when it is shifted
      tx_next[NUM_PADS-1] = cfg.tx_shift.lanes[NUM_LANES-1] & tx_eff[NUM_LANES-1];
   end

   // Receive: a shifted lane picks up the pad above it
   always_comb begin
      for (int j = 0; j < NUM_LANES; j++) begin
         if (cfg.rx_mask.lanes[j]) begin
            rx_next[j] = 1'b0;
         end else if (cfg.rx_shift.lanes[j]) begin
            rx_next[j] = rx_pads[j+1];
         end else begin
            rx_next[j] = rx_pads[j];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         tx_pads  <= '0;
         rx_lanes <= '0;
      end else begin
         tx_pads  <= tx_next;
         rx_lanes <= rx_next;
      end
   end

   // A set bit under a clear bit means the run does not reach bit 31.
   // Half-word programming passes through such states, so only warn
   a_tx_shift_contiguous: assert property (@(posedge clk) disable iff (!reset_n)
      (cfg.tx_shift.lanes[NUM_LANES-2:0] & ~cfg.tx_shift.lanes[NUM_LANES-1:1]) == '0)
      else $warning("tx_shift is not a contiguous run ending at the top lane: %h",
                    cfg.tx_shift.lanes);

endmodule

`default_nettype wire

//--- src/aib_io_redund_top.sv
/*
 * I/O redundancy block: register port plus lane shifter.
 * No wait-request or bursts; every access completes, reads after one cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module aib_io_redund_top
   import aib_avmm_pkg::*;
   import aib_redund_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset_n,
   // Register bus
   input  logic                   read,
   input  logic                   write,
   input  logic [AVMM_ADDR_W-1:0] address,
   input  logic [1:0]             byteenable,
   input  logic [AVMM_DATA_W-1:0] writedata,
   output logic [AVMM_DATA_W-1:0] readdata,
   output logic                   readdatavalid,
   // Data path
   input  logic [NUM_LANES-1:0]   tx_lanes,
   output logic [NUM_PADS-1:0]    tx_pads,
   input  logic [NUM_PADS-1:0]    rx_pads,
   output logic [NUM_LANES-1:0]   rx_lanes
);

   avmm_req_t   req;
   csr_wr_t     wr;
   csr_rd_t     rd;
   redund_cfg_t cfg;

   assign req = '{read: read, write: write, address: address,
                  byteenable: byteenable, writedata: writedata};

   aib_avmm_decode i_decode (
      .clk     (clk),
      .reset_n (reset_n),
      .req     (req),
      .wr      (wr),
      .rd      (rd)
   );

   aib_io_csr i_csr (
      .clk     (clk),
      .reset_n (reset_n),
      .wr      (wr),
      .cfg     (cfg)
   );

   aib_avmm_readback i_readback (
      .clk           (clk),
      .reset_n       (reset_n),
      .rd            (rd),
      .cfg           (cfg),
      .readdata      (readdata),
      .readdatavalid (readdatavalid)
   );

   aib_redund_lane_shift i_lane_shift (
      .clk      (clk),
      .reset_n  (reset_n),
      .cfg      (cfg),
      .tx_lanes (tx_lanes),
      .tx_pads  (tx_pads),
      .rx_pads  (rx_pads),
      .rx_lanes (rx_lanes)
   );

endmodule

`default_nettype wire

//--- sim/tb_aib_io_redund_tasks.svh
/*
 * Bus access, lane check and directed test tasks. Included in the testbench
 * module body; uses its signals, model and expected-value functions.
 */
`ifndef TB_AIB_IO_REDUND_TASKS_SVH
`define TB_AIB_IO_REDUND_TASKS_SVH

task automatic check_value(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
   if (actual !== expected) begin
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "Check failed on %s", name);
   end
endtask

task automatic bus_write(input logic [AVMM_ADDR_W-1:0] addr, input logic [1:0] be,
                         input logic [15:0] data);
   int idx;
   idx = half_index(addr);
   // Unmapped writes leave the model alone
   if (idx >= 0) begin
      model_half[idx] = (model_half[idx] & ~{{8{be[1]}}, {8{be[0]}}})
                        | (data & {{8{be[1]}}, {8{be[0]}}});
   end
   @(posedge clk);
   write      <= 1'b1;
   address    <= addr;
   byteenable <= be;
   writedata  <= data;
   @(posedge clk);
   write <= 1'b0;
endtask

task automatic bus_read(input logic [AVMM_ADDR_W-1:0] addr);
   int cycles;
   int idx;
   idx    = half_index(addr);
   cycles = 0;
   @(posedge clk);
   read    <= 1'b1;
   address <= addr;
   // No response may be pending while the read is still on the bus
   @(negedge clk);
   check_value("readdatavalid", 64'(readdatavalid), 64'd0);
   @(posedge clk);
   read <= 1'b0;
   do begin
      @(negedge clk);
      cycles++;
   end while (!readdatavalid && cycles < READ_TIMEOUT);
   if (!readdatavalid) begin
      $display("No read response from address %h after %0d cycles", addr, cycles);
      $display("Simulation FAILED");
      $fatal(1, "Read timeout");
   end
   check_value("readdatavalid delay", 64'(cycles), 64'd1);
   check_value($sformatf("readdata[%h]", addr), 64'(readdata),
               64'(idx < 0 ? 16'h0 : model_half[idx]));
endtask

task automatic program_word(input int w, input logic [31:0] value);
   bus_write(half_addr[2*w+1], 2'b11, value[31:16]);
   bus_write(half_addr[2*w], 2'b11, value[15:0]);
endtask

task automatic drive_and_check_data(input logic [NUM_LANES-1:0] lanes,
                                    input logic [NUM_PADS-1:0] pads);
   @(posedge clk);
   tx_lanes <= lanes;
   rx_pads  <= pads;
   // One register stage in each direction
   @(posedge clk);
   @(negedge clk);
   check_value("tx_pads", 64'(tx_pads),
               64'(expected_tx(lanes, {model_half[1], model_half[0]},
                               {model_half[7], model_half[6]})));
   check_value("rx_lanes", 64'(rx_lanes),
               64'(expected_rx(pads, {model_half[3], model_half[2]},
                               {model_half[5], model_half[4]})));
endtask

task automatic test_reset_state();
   @(negedge clk);
   check_value("readdatavalid", 64'(readdatavalid), 64'd0);
   check_value("readdata", 64'(readdata), 64'd0);
   for (int i = 0; i < 8; i++) begin
      bus_read(half_addr[i]);
   end
   for (int n = 0; n < 8; n++) begin
      drive_and_check_data($urandom(), {1'($urandom()), $urandom()});
   end
endtask

// Full halves first, then each byte on its own
task automatic test_writes();
   for (int i = 0; i < 8; i++) begin
      bus_write(half_addr[i], 2'b11, 16'($urandom()));
   end
   for (int i = 0; i < 8; i++) begin
      bus_read(half_addr[i]);
      bus_write(half_addr[i], 2'b01, 16'($urandom()));
      bus_read(half_addr[i]);
      bus_write(half_addr[i], 2'b10, 16'($urandom()));
      bus_read(half_addr[i]);
   end
endtask

task automatic test_unmapped();
   logic [AVMM_ADDR_W-1:0] spare [5];
   spare = '{7'h00, 7'h1d, 7'h21, 7'h2c, 7'h7f};
   for (int i = 0; i < 5; i++) begin
      bus_read(spare[i]);
      bus_write(spare[i], 2'b11, 16'($urandom()));
   end
   for (int i = 0; i < 8; i++) begin
      bus_read(half_addr[i]);
   end
endtask

// Shift runs end at bit 31; a shift by 32 leaves the run empty
task automatic test_lane_steering();
   for (int run = 0; run < 4; run++) begin
      program_word(0, 32'hffff_ffff << ($urandom() % 33));
      program_word(1, 32'hffff_ffff << ($urandom() % 33));
      program_word(2, $urandom() & $urandom());
      program_word(3, $urandom());
      for (int n = 0; n < 8; n++) begin
         drive_and_check_data($urandom(), {1'($urandom()), $urandom()});
      end
   end
endtask

`endif

//--- sim/tb_aib_io_redund.sv
/*
 * Directed testbench for the I/O redundancy block. A reference copy of the
 * eight register halves predicts every read and every lane sample.
 * Stops at the first mismatch.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_aib_io_redund
   import aib_avmm_pkg::*;
   import aib_redund_pkg::*;
();

   localparam int CLK_PERIOD   = 100;
   localparam int READ_TIMEOUT = 16;

   logic                   clk;
   logic                   reset_n;
   logic                   read;
   logic                   write;
   logic [AVMM_ADDR_W-1:0] address;
   logic [1:0]             byteenable;
   logic [AVMM_DATA_W-1:0] writedata;
   logic [AVMM_DATA_W-1:0] readdata;
   logic                   readdatavalid;
   logic [NUM_LANES-1:0]   tx_lanes;
   logic [NUM_PADS-1:0]    tx_pads;
   logic [NUM_PADS-1:0]    rx_pads;
   logic [NUM_LANES-1:0]   rx_lanes;

   // Model halves indexed by word*2 + hi in the order of half_addr
   logic [15:0]            model_half [8];
   logic [AVMM_ADDR_W-1:0] half_addr [8];

   aib_io_redund_top i_dut (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD/2) clk = ~clk;
      end
   end

   // Position of a mapped half or -1 for an unmapped address
   function automatic int half_index(input logic [AVMM_ADDR_W-1:0] addr);
      for (int i = 0; i < 8; i++) begin
         if (half_addr[i] == addr) begin
            return i;
         end
      end
      return -1;
   endfunction

   // Pad i carries lane i-1 when shifted, else lane i; the spare pad idles at zero
   function automatic logic [NUM_PADS-1:0] expected_tx(input logic [31:0] lanes,
                                                       input logic [31:0] shift,
                                                       input logic [31:0] mask);
      logic [NUM_PADS-1:0] live;
      logic [NUM_PADS-1:0] pads;
      live = {1'b0, lanes & ~mask};
      pads = live;
      for (int i = 1; i < NUM_PADS; i++) begin
         if (shift[i-1]) begin
            pads[i] = live[i-1];
         end
      end
      return pads;
   endfunction

   // Lane j takes pad j+1 when shifted, masked lanes read zero
   function automatic logic [NUM_LANES-1:0] expected_rx(input logic [NUM_PADS-1:0] pads,
                                                        input logic [31:0] shift,
                                                        input logic [31:0] mask);
      logic [NUM_LANES-1:0] lanes;
      for (int j = 0; j < NUM_LANES; j++) begin
         lanes[j] = shift[j] ? pads[j+1] : pads[j];
      end
      return lanes & ~mask;
   endfunction

   `include "tb_aib_io_redund_tasks.svh"

   initial begin
      void'($urandom(32'h3e8af22a));
      model_half  = '{default: '0};
      half_addr   = '{ADDR_REDUND_0_LO, ADDR_REDUND_0_HI, ADDR_REDUND_1_LO, ADDR_REDUND_1_HI,
                      ADDR_REDUND_2_LO, ADDR_REDUND_2_HI, ADDR_REDUND_3_LO, ADDR_REDUND_3_HI};
      reset_n    <= 1'b0;
      read       <= 1'b0;
      write      <= 1'b0;
      address    <= '0;
      byteenable <= '0;
      writedata  <= '0;
      tx_lanes   <= '0;
      rx_pads    <= '0;
      repeat (4) @(posedge clk);
      reset_n <= 1'b1;
      test_reset_state();
      test_writes();
      test_unmapped();
      test_lane_steering();
      @(posedge clk);
      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+sim
src/aib_avmm_pkg.sv
src/aib_redund_pkg.sv
src/aib_avmm_decode.sv
src/aib_io_csr.sv
src/aib_avmm_readback.sv
src/aib_redund_lane_shift.sv
src/aib_io_redund_top.sv
sim/tb_aib_io_redund.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the I/O redundancy testbench with Verilator
set -euo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
   --top-module tb_aib_io_redund -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
   echo "Run passed"
else
   echo "Run failed, see sim.log"
   exit 1
fi
